//--- build.f
source/ctrl_pkg.sv
source/cmd_framer.sv
source/sensor_link.sv
source/temp_converter.sv
source/alarm_tone.sv
source/reply_mux.sv
source/temp_monitor_top.sv
verif/sensor_model.sv
verif/tb_top.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f build.f -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "sim failed" sim.log || ! grep -q "sim passed" sim.log; then
    exit 1
fi
exit 0

//--- verif/tb_top.sv
`default_nettype none
`timescale 1ns/1ns

module tb_top;
    import ctrl_pkg::*;

    localparam int half_period = 8;
    // {msb, lsb}: +85, +25.0625, -10.125, -55, -0.5
    localparam logic [15:0] chosen_raw [5] = '{16'h0550, 16'h0191, 16'hff5e, 16'hfc90,
                                               16'hfff8};

    logic        clk;
    logic        rst_n;
    byte_t       uart_in;
    logic        uart_in_vld;
    byte_t       intf_rdata;
    logic        intf_rdata_vld;
    logic        intf_rdy;
    byte_t       uart_out;
    logic        uart_out_vld;
    logic        intf_rst_en;
    logic        intf_wr_en;
    byte_t       intf_wdata;
    logic        intf_rd_en;
    logic        beep;
    logic        temp_valid_en;
    logic        fixed_en;
    byte_t       fixed_byte;
    byte_t       last_wdata;

    // reference model state
    logic        arg_phase_r;
    byte_t       op_hold_r;
    logic        c1_vld;
    byte_t       c1_op;
    byte_t       c1_arg;
    logic        link_rd_cmd;
    logic        exp_wr;
    logic        exp_rd;
    logic        exp_reply_vld;
    byte_t       exp_wdata;
    byte_t       exp_reply;
    logic        ref_rst_pend;
    logic        ref_rd_pend;
    byte_t       ref_rd_op;
    byte_t       ref_lsb;
    byte_t       ref_msb;
    byte_t       ref_data;
    logic [31:0] ref_bcd;
    logic [6:0]  ref_deg;
    logic        ref_neg;
    logic        ref_valid_en;
    logic        ref_alarm_en;
    byte_t       ref_low;
    byte_t       ref_high;
    logic        ref_alarm;
    int          ref_cnt;
    logic        ref_beep;

    temp_monitor_top #(
        .beep_half_period (half_period)
    ) DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .uart_in        (uart_in),
        .uart_in_vld    (uart_in_vld),
        .intf_rdata     (intf_rdata),
        .intf_rdata_vld (intf_rdata_vld),
        .intf_rdy       (intf_rdy),
        .uart_out       (uart_out),
        .uart_out_vld   (uart_out_vld),
        .intf_rst_en    (intf_rst_en),
        .intf_wr_en     (intf_wr_en),
        .intf_wdata     (intf_wdata),
        .intf_rd_en     (intf_rd_en),
        .beep           (beep),
        .temp_valid_en  (temp_valid_en)
    );

    sensor_model u_sensor_model (
        .clk            (clk),
        .rst_n          (rst_n),
        .intf_rst_en    (intf_rst_en),
        .intf_wr_en     (intf_wr_en),
        .intf_wdata     (intf_wdata),
        .intf_rd_en     (intf_rd_en),
        .fixed_en       (fixed_en),
        .fixed_byte     (fixed_byte),
        .intf_rdy       (intf_rdy),
        .intf_rdata     (intf_rdata),
        .intf_rdata_vld (intf_rdata_vld),
        .last_wdata     (last_wdata)
    );

    always #10 clk = !clk;

    // magnitude in ten-thousandths of a degree
    function automatic int unsigned scaled_value(input byte_t msb, input byte_t lsb);
        logic [10:0] bits;
        bits = {msb[2:0], lsb};
        if (msb[7]) begin
            bits = 11'(~bits + 11'd1);
        end
        return bits * 625;
    endfunction

    // digits taken from the hundreds down
    function automatic logic [31:0] bcd_word(input logic neg, input int unsigned value);
        logic [31:0] word;
        int unsigned divisor;
        int          k;
        word    = {neg ? 4'hf : 4'h0, 28'h0};
        divisor = 1000000;
        for (k = 6; k >= 0; k--) begin
            word[4*k +: 4] = 4'((value / divisor) % 10);
            divisor = divisor / 10;
        end
        return word;
    endfunction

    function automatic int signed_degrees(input logic neg, input logic [6:0] mag);
        return neg ? -int'(mag) : int'(mag);
    endfunction

    assign link_rd_cmd = c1_vld && (c1_op inside {op_link_rd_lsb, op_link_rd_msb,
                                                  op_link_rd_data});
    assign ref_alarm = ref_alarm_en &&
        (signed_degrees(ref_neg, ref_deg) >= signed_degrees(ref_high[7], ref_high[6:0]) ||
         signed_degrees(ref_neg, ref_deg) < signed_degrees(ref_low[7], ref_low[6:0]));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arg_phase_r   <= 1'b0;
            op_hold_r     <= '0;
            c1_vld        <= 1'b0;
            c1_op         <= '0;
            c1_arg        <= '0;
            exp_wr        <= 1'b0;
            exp_rd        <= 1'b0;
            exp_reply_vld <= 1'b0;
            exp_wdata     <= '0;
            exp_reply     <= '0;
            ref_rst_pend  <= 1'b0;
            ref_rd_pend   <= 1'b0;
            ref_rd_op     <= '0;
            ref_lsb       <= '0;
            ref_msb       <= '0;
            ref_data      <= '0;
            ref_bcd       <= '0;
            ref_deg       <= '0;
            ref_neg       <= 1'b0;
            ref_valid_en  <= 1'b0;
            ref_alarm_en  <= 1'b0;
            ref_low       <= '0;
            ref_high      <= '0;
        end else begin
            c1_vld <= uart_in_vld && arg_phase_r;
            if (uart_in_vld) begin
                arg_phase_r <= !arg_phase_r;
                if (arg_phase_r) begin
                    c1_op  <= op_hold_r;
                    c1_arg <= uart_in;
                end else begin
                    op_hold_r <= uart_in;
                end
            end
            exp_wr        <= c1_vld && c1_op == op_link_wr;
            exp_wdata     <= c1_arg;
            exp_rd        <= link_rd_cmd;
            exp_reply_vld <= c1_vld && c1_op >= op_rd_bcd0 && c1_op <= op_rd_data;
            case (c1_op)
                op_rd_bcd0: exp_reply <= ref_bcd[31:24];
                op_rd_bcd1: exp_reply <= ref_bcd[23:16];
                op_rd_bcd2: exp_reply <= ref_bcd[15:8];
                op_rd_bcd3: exp_reply <= ref_bcd[7:0];
                op_rd_lsb:  exp_reply <= ref_lsb;
                op_rd_msb:  exp_reply <= ref_msb;
                op_rd_data: exp_reply <= ref_data;
                default:    exp_reply <= exp_reply;
            endcase
            if (c1_vld && c1_op == op_link_rst) begin
                ref_rst_pend <= 1'b1;
            end else if (intf_rst_en) begin
                ref_rst_pend <= 1'b0;
            end
            if (link_rd_cmd) begin
                ref_rd_pend <= 1'b1;
                ref_rd_op   <= c1_op;
            end else if (intf_rdata_vld) begin
                ref_rd_pend <= 1'b0;
            end
            if (ref_rd_pend && intf_rdata_vld) begin
                case (ref_rd_op)
                    op_link_rd_lsb: ref_lsb  <= intf_rdata;
                    op_link_rd_msb: ref_msb  <= intf_rdata;
                    default:        ref_data <= intf_rdata;
                endcase
            end
            if (c1_vld && c1_op == op_convert) begin
                ref_bcd <= bcd_word(ref_msb[7], scaled_value(ref_msb, ref_lsb));
                ref_deg <= 7'(scaled_value(ref_msb, ref_lsb) / 10000);
                ref_neg <= ref_msb[7];
            end
            if (c1_vld && c1_op == op_display_en && c1_arg <= 8'h01) begin
                ref_valid_en <= c1_arg[0];
            end
            if (c1_vld && c1_op == op_alarm_en && c1_arg <= 8'h01) begin
                ref_alarm_en <= c1_arg[0];
            end
            if (c1_vld && c1_op == op_set_low) begin
                ref_low <= c1_arg;
            end
            if (c1_vld && c1_op == op_set_high) begin
                ref_high <= c1_arg;
            end
        end
    end

    // expected beeper, half-wave of half_period cycles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ref_cnt  <= 0;
            ref_beep <= 1'b0;
        end else if (!ref_alarm) begin
            ref_cnt <= 0;
        end else if (ref_cnt == half_period - 1) begin
            ref_cnt  <= 0;
            ref_beep <= !ref_beep;
        end else begin
            ref_cnt <= ref_cnt + 1;
        end
    end

    task automatic stop_with_failure();
        $display("sim failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_error(input string msg);
        $display("[ERROR] t=%0t %s", $time, msg);
        stop_with_failure();
    endtask

    a_wr_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        intf_wr_en == exp_wr) else report_error("intf_wr_en differs from expected");
    a_wr_data: assert property (@(posedge clk) disable iff (!rst_n)
        intf_wr_en |-> intf_wdata == exp_wdata) else report_error("wrong intf_wdata");
    a_wr_model: assert property (@(posedge clk) disable iff (!rst_n)
        intf_wr_en |=> last_wdata == $past(exp_wdata))
        else report_error("sensor did not record the written byte");
    a_rd_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        intf_rd_en == exp_rd) else report_error("intf_rd_en differs from expected");
    a_rst_cmd: assert property (@(posedge clk) disable iff (!rst_n)
        intf_rst_en |-> ref_rst_pend) else report_error("intf_rst_en without a reset command");
    a_rst_once: assert property (@(posedge clk) disable iff (!rst_n)
        intf_rst_en |=> !intf_rst_en) else report_error("intf_rst_en longer than one cycle");
    a_rst_idle: assert property (@(posedge clk) disable iff (!rst_n)
        intf_rst_en |-> $past(intf_rdy)) else report_error("intf_rst_en while sensor busy");
    a_reply_vld: assert property (@(posedge clk) disable iff (!rst_n)
        uart_out_vld == exp_reply_vld) else report_error("uart_out_vld differs from expected");
    a_reply_data: assert property (@(posedge clk) disable iff (!rst_n)
        uart_out_vld |-> uart_out == exp_reply) else report_error("wrong reply byte");
    a_display: assert property (@(posedge clk) disable iff (!rst_n)
        temp_valid_en == ref_valid_en) else report_error("wrong temp_valid_en");
    a_beep: assert property (@(posedge clk) disable iff (!rst_n)
        beep == ref_beep) else report_error("beep differs from expected");
    a_beep_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !ref_alarm |=> $stable(beep)) else report_error("beep moved with alarm off");

    task automatic send_pair(input byte_t op, input byte_t arg, input int gap);
        @(posedge clk);
        uart_in     <= op;
        uart_in_vld <= 1'b1;
        @(posedge clk);
        uart_in     <= arg;
        @(posedge clk);
        uart_in_vld <= 1'b0;
        repeat (gap) @(posedge clk);
    endtask

    // until reads and resets on the sensor link are done
    task automatic wait_quiet();
        int n;
        n = 0;
        @(negedge clk);
        while ((ref_rd_pend || ref_rst_pend) && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (ref_rd_pend || ref_rst_pend) begin
            $display("timeout: sensor link still busy after 200 cycles");
            stop_with_failure();
        end
    endtask

    task automatic read_sensor(input byte_t op, input logic use_fixed, input byte_t value);
        @(posedge clk);
        fixed_en   <= use_fixed;
        fixed_byte <= value;
        send_pair(op, 8'h00, 2);
        wait_quiet();
    endtask

    task automatic convert_and_read(input logic use_fixed, input logic [15:0] raw);
        int i;
        read_sensor(op_link_rd_lsb, use_fixed, raw[7:0]);
        read_sensor(op_link_rd_msb, use_fixed, raw[15:8]);
        send_pair(op_convert, 8'h00, 1);
        for (i = 0; i < 4; i++) begin
            send_pair(byte_t'(op_rd_bcd0 + i), 8'h00, 1);
        end
    endtask

    task automatic set_alarm(input byte_t low, input byte_t high, input logic en,
                             input int hold);
        send_pair(op_set_low, low, 0);
        send_pair(op_set_high, high, 0);
        send_pair(op_alarm_en, {7'd0, en}, hold);
    endtask

    initial begin
        int i;
        clk         = 1'b0;
        rst_n       = 1'b0;
        uart_in     = '0;
        uart_in_vld = 1'b0;
        fixed_en    = 1'b0;
        fixed_byte  = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        send_pair(op_link_wr, 8'h5a, 2);
        send_pair(op_link_wr, 8'ha7, 0);

        read_sensor(op_link_rd_lsb, 1'b0, 8'h00);
        send_pair(op_rd_lsb, 8'h00, 2);
        read_sensor(op_link_rd_msb, 1'b0, 8'h00);
        send_pair(op_rd_msb, 8'h00, 2);
        read_sensor(op_link_rd_data, 1'b0, 8'h00);
        send_pair(op_rd_data, 8'h00, 2);

        // second reset lands while the sensor is still busy
        send_pair(op_link_rst, 8'h00, 0);
        send_pair(op_link_rst, 8'h00, 2);
        wait_quiet();

        for (i = 0; i < 5; i++) begin
            convert_and_read(1'b1, chosen_raw[i]);
        end
        repeat (6) convert_and_read(1'b0, 16'h0000);

        convert_and_read(1'b1, 16'h0191);
        set_alarm(8'd20, 8'd30, 1'b1, 30);
        set_alarm(8'd20, 8'd25, 1'b1, 40);
        set_alarm(8'd26, 8'd40, 1'b1, 40);
        set_alarm(8'd20, 8'd30, 1'b1, 20);
        set_alarm(8'd26, 8'd40, 1'b0, 30);
        convert_and_read(1'b1, 16'hff5e);
        set_alarm(8'h85, 8'h14, 1'b1, 40);
        set_alarm(8'h8c, 8'h14, 1'b1, 30);
        // minus half a degree rounds to negative zero
        convert_and_read(1'b1, 16'hfff8);
        set_alarm(8'h85, 8'h80, 1'b1, 40);
        set_alarm(8'h85, 8'h01, 1'b0, 20);

        send_pair(op_display_en, 8'h01, 2);
        send_pair(op_display_en, 8'h07, 2);
        send_pair(op_display_en, 8'h00, 2);
        repeat (4) @(posedge clk);

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/sensor_model.sv
`default_nettype none
`timescale 1ns/1ns

module sensor_model (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            intf_rst_en,
    input  logic            intf_wr_en,
    input  ctrl_pkg::byte_t intf_wdata,
    input  logic            intf_rd_en,
    input  logic            fixed_en,
    input  ctrl_pkg::byte_t fixed_byte,
    output logic            intf_rdy,
    output ctrl_pkg::byte_t intf_rdata,
    output logic            intf_rdata_vld,
    output ctrl_pkg::byte_t last_wdata
);
    import ctrl_pkg::*;

    localparam logic [31:0] seed = 32'h40e7409c;
    localparam logic [31:0] taps = 32'h80200003;

    logic [31:0] lfsr;
    logic [39:0] next_rand;
    logic [1:0]  busy_cnt;
    logic [2:0]  rd_cnt;

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ taps) : (state >> 1);
    endfunction

    // eight steps, one output bit each; new state sits above the byte
    function automatic logic [39:0] take_byte(input logic [31:0] state);
        logic [31:0] s;
        logic [7:0]  b;
        int          i;
        s = state;
        b = '0;
        for (i = 0; i < 8; i++) begin
            b = {b[6:0], s[0]};
            s = lfsr_step(s);
        end
        return {s, b};
    endfunction

    assign next_rand = take_byte(lfsr);
    assign intf_rdy  = (busy_cnt == 2'd0);

    // busy for three cycles after a reset pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_cnt <= 2'd0;
        end else if (intf_rst_en) begin
            busy_cnt <= 2'd3;
        end else if (busy_cnt != 2'd0) begin
            busy_cnt <= busy_cnt - 2'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr           <= seed;
            rd_cnt         <= 3'd0;
            intf_rdata     <= '0;
            intf_rdata_vld <= 1'b0;
            last_wdata     <= '0;
        end else begin
            intf_rdata_vld <= 1'b0;
            if (intf_wr_en) begin
                last_wdata <= intf_wdata;
            end
            if (intf_rd_en) begin
                rd_cnt <= 3'd4;
            end else if (rd_cnt != 3'd0) begin
                rd_cnt <= rd_cnt - 3'd1;
                if (rd_cnt == 3'd1) begin
                    intf_rdata_vld <= 1'b1;
                    intf_rdata     <= fixed_en ? fixed_byte : next_rand[7:0];
                    if (!fixed_en) begin
                        lfsr <= next_rand[39:8];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/temp_monitor_top.sv
`default_nettype none
`timescale 1ns/1ns

module temp_monitor_top #(
    parameter int beep_half_period = 93984
) (
    input  logic            clk,
    input  logic            rst_n,
    input  ctrl_pkg::byte_t uart_in,
    input  logic            uart_in_vld,
    input  ctrl_pkg::byte_t intf_rdata,
    input  logic            intf_rdata_vld,
    input  logic            intf_rdy,
    output ctrl_pkg::byte_t uart_out,
    output logic            uart_out_vld,
    output logic            intf_rst_en,
    output logic            intf_wr_en,
    output ctrl_pkg::byte_t intf_wdata,
    output logic            intf_rd_en,
    output logic            beep,
    output logic            temp_valid_en
);
    import ctrl_pkg::*;

    logic       cmd_vld;
    byte_t      cmd_op;
    byte_t      cmd_arg;
    byte_t      raw_lsb;
    byte_t      raw_msb;
    byte_t      raw_data;
    bcd_word_t  temp_bcd;
    logic [6:0] temp_deg;
    logic       temp_neg;

    cmd_framer u_cmd_framer (
        .clk         (clk),
        .rst_n       (rst_n),
        .uart_in     (uart_in),
        .uart_in_vld (uart_in_vld),
        .cmd_vld     (cmd_vld),
        .cmd_op      (cmd_op),
        .cmd_arg     (cmd_arg)
    );

    sensor_link u_sensor_link (
        .clk            (clk),
        .rst_n          (rst_n),
        .cmd_vld        (cmd_vld),
        .cmd_op         (cmd_op),
        .cmd_arg        (cmd_arg),
        .intf_rdy       (intf_rdy),
        .intf_rdata     (intf_rdata),
        .intf_rdata_vld (intf_rdata_vld),
        .intf_rst_en    (intf_rst_en),
        .intf_wr_en     (intf_wr_en),
        .intf_wdata     (intf_wdata),
        .intf_rd_en     (intf_rd_en),
        .raw_lsb        (raw_lsb),
        .raw_msb        (raw_msb),
        .raw_data       (raw_data)
    );

    temp_converter u_temp_converter (
        .clk           (clk),
        .rst_n         (rst_n),
        .cmd_vld       (cmd_vld),
        .cmd_op        (cmd_op),
        .cmd_arg       (cmd_arg),
        .raw_lsb       (raw_lsb),
        .raw_msb       (raw_msb),
        .temp_bcd      (temp_bcd),
        .temp_deg      (temp_deg),
        .temp_neg      (temp_neg),
        .temp_valid_en (temp_valid_en)
    );

    alarm_tone #(
        .beep_half_period (beep_half_period)
    ) u_alarm_tone (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd_vld  (cmd_vld),
        .cmd_op   (cmd_op),
        .cmd_arg  (cmd_arg),
        .temp_deg (temp_deg),
        .temp_neg (temp_neg),
        .beep     (beep)
    );

    reply_mux u_reply_mux (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_vld      (cmd_vld),
        .cmd_op       (cmd_op),
        .temp_bcd     (temp_bcd),
        .raw_lsb      (raw_lsb),
        .raw_msb      (raw_msb),
        .raw_data     (raw_data),
        .uart_out     (uart_out),
        .uart_out_vld (uart_out_vld)
    );

endmodule

`default_nettype wire

//--- source/reply_mux.sv
`default_nettype none
`timescale 1ns/1ns

module reply_mux (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cmd_vld,
    input  ctrl_pkg::byte_t     cmd_op,
    input  ctrl_pkg::bcd_word_t temp_bcd,
    input  ctrl_pkg::byte_t     raw_lsb,
    input  ctrl_pkg::byte_t     raw_msb,
    input  ctrl_pkg::byte_t     raw_data,
    output ctrl_pkg::byte_t     uart_out,
    output logic                uart_out_vld
);
    import ctrl_pkg::*;

    byte_t reply;
    logic  hit;

    always_comb begin
        hit   = 1'b1;
        reply = '0;
        case (cmd_op)
            op_rd_bcd0: reply = temp_bcd[31:24];
            op_rd_bcd1: reply = temp_bcd[23:16];
            op_rd_bcd2: reply = temp_bcd[15:8];
            op_rd_bcd3: reply = temp_bcd[7:0];
            op_rd_lsb:  reply = raw_lsb;
            op_rd_msb:  reply = raw_msb;
            op_rd_data: reply = raw_data;
            default:    hit   = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            uart_out_vld <= 1'b0;
            uart_out     <= '0;
        end else begin
            uart_out_vld <= cmd_vld && hit;
            // last reply stays on the bus
            if (cmd_vld && hit) begin
                uart_out <= reply;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/alarm_tone.sv
`default_nettype none
`timescale 1ns/1ns

module alarm_tone #(
    parameter int beep_half_period = 93984
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cmd_vld,
    input  ctrl_pkg::byte_t cmd_op,
    input  ctrl_pkg::byte_t cmd_arg,
    input  logic [6:0]      temp_deg,
    input  logic            temp_neg,
    output logic            beep
);
    import ctrl_pkg::*;

    localparam int cnt_w = $clog2(beep_half_period + 1);

    byte_t              low_thr;
    byte_t              high_thr;
    logic               alarm_en;
    logic signed [8:0]  temp_s;
    logic signed [8:0]  low_s;
    logic signed [8:0]  high_s;
    logic               alarm;
    logic [cnt_w-1:0]   cnt;

    // sign-magnitude to signed, minus zero folds to zero
    function automatic logic signed [8:0] sm_to_int(input logic neg, input logic [6:0] mag);
        logic signed [8:0] value;
        value = $signed({2'b00, mag});
        return neg ? -value : value;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            low_thr  <= '0;
            high_thr <= '0;
            alarm_en <= 1'b0;
        end else if (cmd_vld) begin
            case (cmd_op)
                op_set_low:  low_thr  <= cmd_arg;
                op_set_high: high_thr <= cmd_arg;
                op_alarm_en: begin
                    if (cmd_arg == 8'h01) begin
                        alarm_en <= 1'b1;
                    end else if (cmd_arg == 8'h00) begin
                        alarm_en <= 1'b0;
                    end
                end
                default: ;
            endcase
        end
    end

    assign temp_s = sm_to_int(temp_neg, temp_deg);
    assign low_s  = sm_to_int(low_thr[7], low_thr[6:0]);
    assign high_s = sm_to_int(high_thr[7], high_thr[6:0]);
    assign alarm  = alarm_en && (temp_s >= high_s || temp_s < low_s);

    // square wave while the alarm holds, level kept when it ends
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt  <= '0;
            beep <= 1'b0;
        end else if (!alarm) begin
            cnt <= '0;
        end else if (cnt == cnt_w'(beep_half_period - 1)) begin
            cnt  <= '0;
            beep <= !beep;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- source/temp_converter.sv
`default_nettype none
`timescale 1ns/1ns

module temp_converter (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cmd_vld,
    input  ctrl_pkg::byte_t     cmd_op,
    input  ctrl_pkg::byte_t     cmd_arg,
    input  ctrl_pkg::byte_t     raw_lsb,
    input  ctrl_pkg::byte_t     raw_msb,
    output ctrl_pkg::bcd_word_t temp_bcd,
    output logic [6:0]          temp_deg,
    output logic                temp_neg,
    output logic                temp_valid_en
);
    import ctrl_pkg::*;

    localparam int scaled_w  = 24;
    localparam int deg_scale = 10000;

    logic [raw_width-1:0] mag_raw;
    logic [raw_width-1:0] mag;
    logic [scaled_w-1:0]  scaled;
    logic [scaled_w-1:0]  scaled_q;
    logic                 do_convert;

    // digits of a binary value, least significant first
    function automatic logic [4*bcd_digits-1:0] to_bcd(input logic [scaled_w-1:0] value);
        logic [scaled_w-1:0]     rest;
        logic [4*bcd_digits-1:0] digits;
        int                      i;
        rest   = value;
        digits = '0;
        for (i = 0; i < bcd_digits; i++) begin
            digits[4*i +: 4] = 4'(rest % 10);
            rest = rest / 10;
        end
        return digits;
    endfunction

    assign mag_raw    = {raw_msb[2:0], raw_lsb};
    assign mag        = raw_msb[7] ? raw_width'(~mag_raw + 1'b1) : mag_raw;
    assign scaled     = scaled_w'(mag * lsb_weight);
    assign do_convert = cmd_vld && (cmd_op == op_convert);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            temp_bcd <= '0;
            scaled_q <= '0;
            temp_neg <= 1'b0;
        end else if (do_convert) begin
            temp_bcd <= {raw_msb[7] ? 4'hf : 4'h0, to_bcd(scaled)};
            scaled_q <= scaled;
            temp_neg <= raw_msb[7];
        end
    end

    // whole degrees for the alarm compare
    assign temp_deg = 7'(scaled_q / deg_scale);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            temp_valid_en <= 1'b0;
        end else if (cmd_vld && cmd_op == op_display_en) begin
            if (cmd_arg == 8'h01) begin
                temp_valid_en <= 1'b1;
            end else if (cmd_arg == 8'h00) begin
                temp_valid_en <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/sensor_link.sv
`default_nettype none
`timescale 1ns/1ns

module sensor_link (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cmd_vld,
    input  ctrl_pkg::byte_t cmd_op,
    input  ctrl_pkg::byte_t cmd_arg,
    input  logic            intf_rdy,
    input  ctrl_pkg::byte_t intf_rdata,
    input  logic            intf_rdata_vld,
    output logic            intf_rst_en,
    output logic            intf_wr_en,
    output ctrl_pkg::byte_t intf_wdata,
    output logic            intf_rd_en,
    output ctrl_pkg::byte_t raw_lsb,
    output ctrl_pkg::byte_t raw_msb,
    output ctrl_pkg::byte_t raw_data
);
    import ctrl_pkg::*;

    logic  rst_req;
    logic  wr_req;
    logic  rd_req;
    logic  rst_pend;
    logic  rd_pend;
    logic  capture;
    byte_t rd_op;

    assign rst_req = cmd_vld && (cmd_op == op_link_rst);
    assign wr_req  = cmd_vld && (cmd_op == op_link_wr);
    assign rd_req  = cmd_vld && (cmd_op == op_link_rd_lsb ||
                                 cmd_op == op_link_rd_msb ||
                                 cmd_op == op_link_rd_data);
    assign capture = rd_pend && intf_rdata_vld;

    // reset waits for an idle interface
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rst_pend    <= 1'b0;
            intf_rst_en <= 1'b0;
        end else begin
            intf_rst_en <= rst_pend && intf_rdy;
            if (rst_req) begin
                rst_pend <= 1'b1;
            end else if (intf_rdy) begin
                rst_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            intf_wr_en <= 1'b0;
            intf_rd_en <= 1'b0;
            rd_pend    <= 1'b0;
        end else begin
            intf_wr_en <= wr_req;
            intf_rd_en <= rd_req;
            if (rd_req) begin
                rd_pend <= 1'b1;
            end else if (intf_rdata_vld) begin
                rd_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_req) begin
            intf_wdata <= cmd_arg;
        end
        // a newer read retargets the slot
        if (rd_req) begin
            rd_op <= cmd_op;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            raw_lsb  <= '0;
            raw_msb  <= '0;
            raw_data <= '0;
        end else if (capture) begin
            case (rd_op)
                op_link_rd_lsb: raw_lsb  <= intf_rdata;
                op_link_rd_msb: raw_msb  <= intf_rdata;
                default:        raw_data <= intf_rdata;
            endcase
        end
    end

    a_rst_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(intf_rst_en) |-> $past(intf_rdy));

endmodule

`default_nettype wire

//--- source/cmd_framer.sv
`default_nettype none
`timescale 1ns/1ns

module cmd_framer (
    input  logic            clk,
    input  logic            rst_n,
    input  ctrl_pkg::byte_t uart_in,
    input  logic            uart_in_vld,
    output logic            cmd_vld,
    output ctrl_pkg::byte_t cmd_op,
    output ctrl_pkg::byte_t cmd_arg
);
    import ctrl_pkg::*;

    // high while waiting for the argument byte
    logic  arg_phase;
    byte_t op_hold;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arg_phase <= 1'b0;
            cmd_vld   <= 1'b0;
        end else begin
            cmd_vld <= uart_in_vld && arg_phase;
            if (uart_in_vld) begin
                arg_phase <= !arg_phase;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (uart_in_vld && !arg_phase) begin
            op_hold <= uart_in;
        end
        if (uart_in_vld && arg_phase) begin
            cmd_op  <= op_hold;
            cmd_arg <= uart_in;
        end
    end

    // opcode and argument need two bytes, so no back-to-back commands
    a_cmd_single: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_vld |=> !cmd_vld);

endmodule

`default_nettype wire

//--- source/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    // one byte on the uart and sensor data paths
    typedef logic [7:0] byte_t;

    // sign nibble over seven bcd digits, hundreds down to 1e-4 degrees
    typedef logic [31:0] bcd_word_t;

    // host command opcodes
    localparam byte_t op_display_en   = 8'h01;
    localparam byte_t op_set_low      = 8'h02;
    localparam byte_t op_set_high     = 8'h03;
    localparam byte_t op_convert      = 8'h04;
    localparam byte_t op_alarm_en     = 8'h05;
    localparam byte_t op_rd_bcd0      = 8'h06;
    localparam byte_t op_rd_bcd1      = 8'h07;
    localparam byte_t op_rd_bcd2      = 8'h08;
    localparam byte_t op_rd_bcd3      = 8'h09;
    localparam byte_t op_rd_lsb       = 8'h0a;
    localparam byte_t op_rd_msb       = 8'h0b;
    localparam byte_t op_rd_data      = 8'h0c;

    // sensor interface opcodes
    localparam byte_t op_link_rst     = 8'h80;
    localparam byte_t op_link_wr      = 8'h81;
    localparam byte_t op_link_rd_lsb  = 8'h82;
    localparam byte_t op_link_rd_msb  = 8'h83;
    localparam byte_t op_link_rd_data = 8'h84;

    // magnitude bits of the raw reading
    localparam int raw_width = 11;

    // one raw step is 0.0625 degrees
    localparam int unsigned lsb_weight = 625;

    localparam int bcd_digits = 7;

endpackage

`default_nettype wire
